//--- run_sim.sh
#!/bin/sh
# Build the single-cycle core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --assert --timescale 1ns/100ps -Wno-fatal --top-module cpu_tb \
  -f verilog.f -o cpu_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/cpu_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0

//--- sim/cpu_props.sv
/* Core port properties
   Concurrent checks on the data port and fetch address, bound to the core */

`timescale 1ns/100ps

`include "riscv_config.svh"

module cpu_props (
  input logic                   clk,
  input logic                   arst_n,
  input logic [`RISCV_XLEN-1:0] imem_addr,
  input riscv_pkg::dmem_req_t   dmem_req
);

  // One instruction never loads and stores at once
  rd_wr_exclusive: assert property (
    @(posedge clk) disable iff (!arst_n) !(dmem_req.read && dmem_req.write)
  ) else $error("data port shows read and write together");

  // Fetch stays on word boundaries
  fetch_aligned: assert property (@(posedge clk) imem_addr[1:0] == 2'b00)
    else $error("imem_addr not word aligned: %h", imem_addr);

  // Stores are held off while reset is low
  no_store_in_reset: assert property (@(posedge clk) !arst_n |-> !dmem_req.write)
    else $error("data write seen during reset");

endmodule

//--- sim/cpu_tb.sv
/* Single-cycle RV32I core testbench
   Random program from an LFSR, memory models, an instruction-level
   reference model and a compare process on the falling edge */

`timescale 1ns/100ps

`include "riscv_config.svh"

module cpu_tb;
  import riscv_pkg::*;

  localparam int mem_words    = 256;
  localparam int reset_cycles = 16;
  localparam int rounds       = 36;

  typedef struct packed {
    logic [31:0] next_pc;
    logic        store;
    logic        load;
    logic [31:0] addr;
    logic [31:0] data;
  } step_t;

  logic                   clk;
  logic                   arst_n;
  logic [`RISCV_XLEN-1:0] imem_addr;
  logic [`RISCV_XLEN-1:0] imem_rdata = 32'h0000_0013;
  dmem_req_t              dmem_req;
  logic [`RISCV_XLEN-1:0] dmem_rdata;

  logic [31:0] imem [mem_words];
  logic [31:0] dmem [mem_words];
  logic [31:0] model_mem [mem_words];
  logic [31:0] model_regs [32];
  logic [31:0] model_pc = `RISCV_RESET_PC;
  logic [31:0] lfsr_state = 32'h996b_dcfa;
  logic [31:0] end_pc = '0;
  logic [31:0] wr_addr = '0;
  logic [31:0] wr_data = '0;
  logic        wr_seen = 1'b0;
  logic        rd_seen = 1'b0;
  logic        gen_done = 1'b0;
  logic        done = 1'b0;
  int          prog_len = 0;
  step_t       expected;

  tb_clock clock0 (.clk (clk));

  singlecycle_cpu dut0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata)
  );

  bind singlecycle_cpu cpu_props props0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .imem_addr (imem_addr),
    .dmem_req  (dmem_req)
  );

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r[i] = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
    return r;
  endfunction

  // Registers x0..x7 only, so every source is written before use
  function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = rand_bits(3);
    return r[4:0];
  endfunction

  function automatic logic [31:0] fill_word(int idx);
    logic [31:0] a;
    a = 32'(idx) << 2;
    return (a * 32'h9e37_79b9) ^ {a[15:0], ~a[15:0]};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  // SW only
  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(logic [31:0] inst);
    imem[prog_len] = inst;
    prog_len++;
  endtask

  function automatic logic [31:0] alu_model(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'b000: r = alt ? a - b : a + b;
      3'b001: r = a << b[4:0];
      3'b010: r = {31'b0, $signed(a) < $signed(b)};
      3'b011: r = {31'b0, a < b};
      3'b100: r = a ^ b;
      3'b101: begin
        if (alt)
          r = $signed(a) >>> b[4:0];
        else
          r = a >> b[4:0];
      end
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // Executes one instruction on the architectural model
  function automatic step_t ref_step(logic [31:0] inst);
    step_t       s;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a, b, imm_i, imm_s, imm_b, imm_u, imm_j, ea, val;
    logic        wr, take;
    rd    = inst[11:7];
    f3    = inst[14:12];
    a     = model_regs[inst[19:15]];
    b     = model_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u = {inst[31:12], 12'b0};
    imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    s         = '0;
    s.next_pc = model_pc + 32'd4;
    wr        = 1'b0;
    val       = '0;
    take      = 1'b0;
    ea        = '0;
    case (inst[6:0])
      7'b0110111: begin
        wr  = 1'b1;
        val = imm_u;
      end
      7'b0010111: begin
        wr  = 1'b1;
        val = model_pc + imm_u;
      end
      7'b1101111: begin
        wr        = 1'b1;
        val       = model_pc + 32'd4;
        s.next_pc = model_pc + imm_j;
      end
      7'b1100111: begin
        wr        = 1'b1;
        val       = model_pc + 32'd4;
        s.next_pc = (a + imm_i) & ~32'd1;
      end
      7'b1100011: begin
        case (f3)
          3'b000: take = (a == b);
          3'b001: take = (a != b);
          3'b100: take = ($signed(a) < $signed(b));
          3'b101: take = ($signed(a) >= $signed(b));
          3'b110: take = (a < b);
          3'b111: take = (a >= b);
          default: take = 1'b0;
        endcase
        if (take)
          s.next_pc = model_pc + imm_b;
      end
      7'b0000011: begin
        wr     = 1'b1;
        ea     = a + imm_i;
        s.load = 1'b1;
        val    = model_mem[ea[9:2]];
      end
      7'b0100011: begin
        ea      = a + imm_s;
        s.store = 1'b1;
        s.addr  = ea;
        s.data  = b;
        model_mem[ea[9:2]] = b;
      end
      7'b0010011: begin
        wr  = 1'b1;
        val = alu_model(f3, (f3 == 3'b101) && inst[30], a, imm_i);
      end
      7'b0110011: begin
        wr  = 1'b1;
        val = alu_model(f3, inst[30], a, b);
      end
      default: begin
      end
    endcase
    if (wr && rd != 5'd0)
      model_regs[rd] = val;
    model_pc = s.next_pc;
    return s;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Data memory, written at the rising edge, read combinationally
  assign dmem_rdata = dmem[dmem_req.addr[9:2]];

  always @(posedge clk) begin
    if (dmem_req.write)
      dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
    wr_seen <= dmem_req.write;
    rd_seen <= dmem_req.read;
    wr_addr <= dmem_req.addr;
    wr_data <= dmem_req.wdata;
  end

  // Compare the retired instruction, then fetch for the next one
  always @(negedge clk) begin
    if (!arst_n) begin
      check_value("imem_addr", imem_addr, `RISCV_RESET_PC);
      check_value("dmem_req.write", {31'b0, wr_seen}, 32'h0);
    end else if (!done) begin
      expected = ref_step(imem[model_pc[9:2]]);
      check_value("imem_addr", imem_addr, expected.next_pc);
      check_value("dmem_req.write", {31'b0, wr_seen}, {31'b0, expected.store});
      check_value("dmem_req.read", {31'b0, rd_seen}, {31'b0, expected.load});
      if (expected.store) begin
        check_value("dmem_req.addr", wr_addr, expected.addr);
        check_value("dmem_req.wdata", wr_data, expected.data);
      end
      if (expected.next_pc == end_pc)
        done <= 1'b1;
    end
    imem_rdata <= imem[imem_addr[9:2]];
  end

  initial begin
    wait (gen_done);
    #((prog_len + reset_cycles + 40) * 20);
    $display("Watchdog expired before the program reached its end");
    $display("TESTS FAILED");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    logic [31:0] r;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [11:0] imm, addr_a, addr_b;
    int          kind;
    arst_n = 1'b0;
    for (int i = 0; i < mem_words; i++) begin
      imem[i]      = 32'h0000_0013;
      dmem[i]      = fill_word(i);
      model_mem[i] = fill_word(i);
    end
    for (int i = 0; i < 32; i++)
      model_regs[i] = '0;

    // A store sits at the reset PC for the whole reset phase
    emit(enc_s(12'h000, 5'd0, 5'd0));

    // Random start values in x1..x7
    for (int i = 1; i < 8; i++) begin
      r = rand_bits(32);
      emit(enc_u(r[31:12], 5'(i), opc_lui));
      emit(enc_i(r[11:0], 5'(i), 3'b000, 5'(i), opc_op_imm));
    end

    for (int n = 0; n < rounds; n++) begin
      r      = rand_bits(3);
      kind   = int'(r);
      rd     = rand_reg();
      rs1    = rand_reg();
      rs2    = rand_reg();
      r      = rand_bits(12);
      imm    = r[11:0];
      r      = rand_bits(8);
      addr_a = {2'b00, r[7:0], 2'b00};
      case (kind)
        1: begin
          r  = rand_bits(4);
          f3 = r[2:0];
          if (f3 == 3'b001)
            imm = {7'b0, imm[4:0]};
          else if (f3 == 3'b101)
            imm = {1'b0, r[3], 5'b0, imm[4:0]};
          emit(enc_i(imm, rs1, f3, rd, opc_op_imm));
          emit(enc_s(addr_a, rd, 5'd0));
        end
        2: begin
          r = rand_bits(21);
          emit(enc_u(r[19:0], rd, r[20] ? opc_auipc : opc_lui));
          emit(enc_s(addr_a, rd, 5'd0));
        end
        3: begin
          r  = rand_bits(3);
          f3 = (r[2:1] == 2'b01) ? {1'b1, r[1:0]} : r[2:0];
          // Taken branch skips the ADDI after it
          emit(enc_b(13'd8, rs2, rs1, f3));
          emit(enc_i(imm, rs1, 3'b000, rd, opc_op_imm));
        end
        4: begin
          emit(enc_j(21'd8, rd));
          emit(enc_i(imm, rs1, 3'b000, rs2, opc_op_imm));
          emit(enc_s(addr_a, rd, 5'd0));
        end
        5: begin
          // Odd offset, target lands on the SW
          emit(enc_u(20'd0, 5'd5, opc_auipc));
          emit(enc_i(12'd13, 5'd5, 3'b000, rd, opc_jalr));
          emit(enc_i(imm, rs1, 3'b000, rs2, opc_op_imm));
          emit(enc_s(addr_a, rd, 5'd0));
        end
        6: begin
          r      = rand_bits(8);
          addr_b = {2'b00, r[7:0], 2'b00};
          emit(enc_s(addr_a, rs2, 5'd0));
          emit(enc_i(addr_a, 5'd0, 3'b010, rd, opc_load));
          emit(enc_s(addr_b, rd, 5'd0));
        end
        default: begin
          r  = rand_bits(4);
          f3 = r[2:0];
          emit(enc_r((f3 == 3'b000 || f3 == 3'b101) ? {1'b0, r[3], 5'b0} : 7'b0,
                     rs2, rs1, f3, rd, opc_op));
          emit(enc_s(addr_a, rd, 5'd0));
        end
      endcase
    end
    end_pc   = `RISCV_RESET_PC + 32'(prog_len * 4);
    gen_done = 1'b1;

    repeat (reset_cycles) @(negedge clk);
    arst_n <= 1'b1;
    wait (done);
    @(negedge clk);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- sim/tb_clock.sv
/* Testbench clock source
   Free-running clock with a 20 ns period */

`timescale 1ns/100ps

module tb_clock #(
  parameter int half_period = 10
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

endmodule

//--- verilog.f
+incdir+verilog
verilog/riscv_pkg.sv
verilog/singlecycle_control.sv
verilog/control_transfer.sv
verilog/alu_control.sv
verilog/singlecycle_ctlpath.sv
verilog/singlecycle_datapath.sv
verilog/singlecycle_cpu.sv
sim/tb_clock.sv
sim/cpu_props.sv
sim/cpu_tb.sv

//--- verilog/alu_control.sv
/* ALU function decoder
   Maps operation class, funct3 and funct7 onto one ALU operation */

`timescale 1ns/100ps

module alu_control (
  input  riscv_pkg::alu_op_type_e  alu_op_type,
  input  logic [2:0]               inst_funct3,
  input  logic [6:0]               inst_funct7,
  output riscv_pkg::alu_function_e alu_function
);
  import riscv_pkg::*;

  logic alt_op;

  // funct7 bit 5 marks sub and sra
  assign alt_op = inst_funct7[5];

  always_comb begin
    alu_function = alu_add;
    case (alu_op_type)
      aop_branch: begin
        case (inst_funct3)
          3'b100, 3'b101: alu_function = alu_slt;
          3'b110, 3'b111: alu_function = alu_sltu;
          default:        alu_function = alu_sub;
        endcase
      end
      aop_op_imm, aop_op: begin
        case (inst_funct3)
          3'b000: begin
            // No subi, so only register ops honour the alternate bit
            if (alu_op_type == aop_op && alt_op)
              alu_function = alu_sub;
            else
              alu_function = alu_add;
          end
          3'b001: alu_function = alu_sll;
          3'b010: alu_function = alu_slt;
          3'b011: alu_function = alu_sltu;
          3'b100: alu_function = alu_xor;
          3'b101: alu_function = alt_op ? alu_sra : alu_srl;
          3'b110: alu_function = alu_or;
          default: alu_function = alu_and;
        endcase
      end
      default: alu_function = alu_add;
    endcase
  end

endmodule

//--- verilog/control_transfer.sv
/* Branch decision unit
   Resolves the six branch conditions from funct3 and the ALU zero flag */

`timescale 1ns/100ps

module control_transfer (
  input  logic       result_equal_zero,
  input  logic [2:0] inst_funct3,
  output logic       take_branch
);

  // ALU ran sub for eq/ne and slt/sltu for the ordered compares
  always_comb begin
    case (inst_funct3)
      // beq
      3'b000: take_branch = result_equal_zero;
      // bne
      3'b001: take_branch = !result_equal_zero;
      // blt, slt gives one when less
      3'b100: take_branch = !result_equal_zero;
      // bge
      3'b101: take_branch = result_equal_zero;
      // bltu
      3'b110: take_branch = !result_equal_zero;
      // bgeu
      3'b111: take_branch = result_equal_zero;
      default: take_branch = 1'b0;
    endcase
  end

endmodule

//--- verilog/riscv_config.svh
/* RV32I core configuration
   Reset vector, data word width and register file depth */

`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// Program counter value after reset
`define RISCV_RESET_PC 32'h0000_0000

// Data word width in bits
`define RISCV_XLEN 32

// Register file entries, x0 included
`define RISCV_NUM_REGS 32

`endif

//--- verilog/riscv_pkg.sv
/* RV32I core types
   Opcode, ALU, writeback and next-PC encodings plus the control
   and data port structs shared by the control path and datapath */

`include "riscv_config.svh"

package riscv_pkg;

  // Base opcodes of the supported subset
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_auipc  = 7'b0010111,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111
  } opcode_e;

  // Operation class handed from main decoder to ALU decoder
  typedef enum logic [1:0] {
    aop_add    = 2'd0,
    aop_branch = 2'd1,
    aop_op_imm = 2'd2,
    aop_op     = 2'd3
  } alu_op_type_e;

  typedef enum logic [4:0] {
    alu_add  = 5'd0,
    alu_sub  = 5'd1,
    alu_sll  = 5'd2,
    alu_slt  = 5'd3,
    alu_sltu = 5'd4,
    alu_xor  = 5'd5,
    alu_srl  = 5'd6,
    alu_sra  = 5'd7,
    alu_or   = 5'd8,
    alu_and  = 5'd9,
    alu_seq  = 5'd10,
    alu_sne  = 5'd11
  } alu_function_e;

  typedef enum logic [2:0] {
    wb_alu      = 3'd0,
    wb_mem      = 3'd1,
    wb_pc_plus4 = 3'd2,
    wb_imm      = 3'd3
  } writeback_sel_e;

  typedef enum logic [1:0] {
    pc_seq           = 2'd0,
    pc_branch_target = 2'd1,
    pc_jalr_target   = 2'd2
  } next_pc_sel_e;

  // Operand selects: a is 0 for rs1, 1 for PC; b is 0 for rs2, 1 for immediate
  typedef struct packed {
    logic           pc_write_enable;
    logic           regfile_write_enable;
    logic           alu_operand_a_select;
    logic           alu_operand_b_select;
    logic           data_mem_read_enable;
    logic           data_mem_write_enable;
    writeback_sel_e reg_writeback_select;
    alu_function_e  alu_function;
    next_pc_sel_e   next_pc_select;
  } ctrl_signals_t;

  typedef struct packed {
    logic [`RISCV_XLEN-1:0] addr;
    logic [`RISCV_XLEN-1:0] wdata;
    logic                   read;
    logic                   write;
  } dmem_req_t;

endpackage

//--- verilog/singlecycle_control.sv
/* Main decoder
   Turns the opcode and branch decision into enables, operand
   selects, writeback source and ALU operation class */

`timescale 1ns/100ps

module singlecycle_control (
  input  logic [6:0]               inst_opcode,
  input  logic                     take_branch,
  output riscv_pkg::ctrl_signals_t ctrl_main,
  output riscv_pkg::alu_op_type_e  alu_op_type
);
  import riscv_pkg::*;

  always_comb begin
    // Defaults describe a NOP that only advances the PC
    ctrl_main                      = '0;
    ctrl_main.pc_write_enable      = 1'b1;
    ctrl_main.reg_writeback_select = wb_alu;
    ctrl_main.alu_function         = alu_add;
    ctrl_main.next_pc_select       = pc_seq;
    alu_op_type                    = aop_add;

    case (opcode_e'(inst_opcode))
      opc_lui: begin
        ctrl_main.regfile_write_enable = 1'b1;
        ctrl_main.reg_writeback_select = wb_imm;
      end
      opc_auipc: begin
        ctrl_main.regfile_write_enable = 1'b1;
        ctrl_main.alu_operand_a_select = 1'b1;
        ctrl_main.alu_operand_b_select = 1'b1;
      end
      opc_jal: begin
        ctrl_main.regfile_write_enable = 1'b1;
        ctrl_main.reg_writeback_select = wb_pc_plus4;
        ctrl_main.next_pc_select       = pc_branch_target;
      end
      opc_jalr: begin
        ctrl_main.regfile_write_enable = 1'b1;
        ctrl_main.alu_operand_b_select = 1'b1;
        ctrl_main.reg_writeback_select = wb_pc_plus4;
        ctrl_main.next_pc_select       = pc_jalr_target;
      end
      opc_branch: begin
        alu_op_type              = aop_branch;
        ctrl_main.next_pc_select = take_branch ? pc_branch_target : pc_seq;
      end
      opc_load: begin
        ctrl_main.regfile_write_enable = 1'b1;
        ctrl_main.alu_operand_b_select = 1'b1;
        ctrl_main.data_mem_read_enable = 1'b1;
        ctrl_main.reg_writeback_select = wb_mem;
      end
      opc_store: begin
        ctrl_main.alu_operand_b_select  = 1'b1;
        ctrl_main.data_mem_write_enable = 1'b1;
      end
      opc_op_imm: begin
        ctrl_main.regfile_write_enable = 1'b1;
        ctrl_main.alu_operand_b_select = 1'b1;
        alu_op_type                    = aop_op_imm;
      end
      opc_op: begin
        ctrl_main.regfile_write_enable = 1'b1;
        alu_op_type                    = aop_op;
      end
      default: begin
      end
    endcase
  end

endmodule

//--- verilog/singlecycle_cpu.sv
/* Single-cycle RV32I core
   Joins the control path and datapath to the fetch and data ports */

`timescale 1ns/100ps

`include "riscv_config.svh"

module singlecycle_cpu (
  input  logic                   clk,
  input  logic                   arst_n,
  output logic [`RISCV_XLEN-1:0] imem_addr,
  input  logic [`RISCV_XLEN-1:0] imem_rdata,
  output riscv_pkg::dmem_req_t   dmem_req,
  input  logic [`RISCV_XLEN-1:0] dmem_rdata
);
  import riscv_pkg::*;

  ctrl_signals_t ctrl;
  logic [6:0]    inst_opcode;
  logic [2:0]    inst_funct3;
  logic [6:0]    inst_funct7;
  logic          alu_result_equal_zero;

  singlecycle_ctlpath ctlpath0 (
    .inst_opcode           (inst_opcode),
    .inst_funct3           (inst_funct3),
    .inst_funct7           (inst_funct7),
    .alu_result_equal_zero (alu_result_equal_zero),
    .ctrl                  (ctrl)
  );

  singlecycle_datapath datapath0 (
    .clk                   (clk),
    .arst_n                (arst_n),
    .ctrl                  (ctrl),
    .imem_rdata            (imem_rdata),
    .dmem_rdata            (dmem_rdata),
    .imem_addr             (imem_addr),
    .dmem_req              (dmem_req),
    .inst_opcode           (inst_opcode),
    .inst_funct3           (inst_funct3),
    .inst_funct7           (inst_funct7),
    .alu_result_equal_zero (alu_result_equal_zero)
  );

endmodule

//--- verilog/singlecycle_ctlpath.sv
/* Control path
   Feeds the instruction fields to the main decoder, branch unit and
   ALU decoder and merges their results into one control struct */

`timescale 1ns/100ps

module singlecycle_ctlpath (
  input  logic [6:0]               inst_opcode,
  input  logic [2:0]               inst_funct3,
  input  logic [6:0]               inst_funct7,
  input  logic                     alu_result_equal_zero,
  output riscv_pkg::ctrl_signals_t ctrl
);
  import riscv_pkg::*;

  ctrl_signals_t ctrl_main;
  alu_op_type_e  alu_op_type;
  alu_function_e alu_function;
  logic          take_branch;

  singlecycle_control control (
    .inst_opcode (inst_opcode),
    .take_branch (take_branch),
    .ctrl_main   (ctrl_main),
    .alu_op_type (alu_op_type)
  );

  control_transfer transfer (
    .result_equal_zero (alu_result_equal_zero),
    .inst_funct3       (inst_funct3),
    .take_branch       (take_branch)
  );

  alu_control alu_ctrl (
    .alu_op_type  (alu_op_type),
    .inst_funct3  (inst_funct3),
    .inst_funct7  (inst_funct7),
    .alu_function (alu_function)
  );

  // Main decoder leaves the ALU function open
  always_comb begin
    ctrl              = ctrl_main;
    ctrl.alu_function = alu_function;
  end

endmodule

//--- verilog/singlecycle_datapath.sv
/* Single-cycle datapath
   PC register, register file, immediate generator, ALU,
   writeback selection and next-PC logic */

`timescale 1ns/100ps

`include "riscv_config.svh"

module singlecycle_datapath (
  input  logic                   clk,
  input  logic                   arst_n,
  input  riscv_pkg::ctrl_signals_t ctrl,
  input  logic [`RISCV_XLEN-1:0] imem_rdata,
  input  logic [`RISCV_XLEN-1:0] dmem_rdata,
  output logic [`RISCV_XLEN-1:0] imem_addr,
  output riscv_pkg::dmem_req_t   dmem_req,
  output logic [6:0]             inst_opcode,
  output logic [2:0]             inst_funct3,
  output logic [6:0]             inst_funct7,
  output logic                   alu_result_equal_zero
);
  import riscv_pkg::*;

  localparam int reg_aw = $clog2(`RISCV_NUM_REGS);
  localparam int shamt_w = $clog2(`RISCV_XLEN);

  logic [`RISCV_XLEN-1:0] pc;
  logic [`RISCV_XLEN-1:0] pc_plus4;
  logic [`RISCV_XLEN-1:0] next_pc;
  logic [`RISCV_XLEN-1:0] regs [`RISCV_NUM_REGS];
  logic [reg_aw-1:0]      rs1_addr;
  logic [reg_aw-1:0]      rs2_addr;
  logic [reg_aw-1:0]      rd_addr;
  logic [`RISCV_XLEN-1:0] rs1_data;
  logic [`RISCV_XLEN-1:0] rs2_data;
  logic                   rf_write;
  logic [`RISCV_XLEN-1:0] imm_i;
  logic [`RISCV_XLEN-1:0] imm_s;
  logic [`RISCV_XLEN-1:0] imm_b;
  logic [`RISCV_XLEN-1:0] imm_u;
  logic [`RISCV_XLEN-1:0] imm_j;
  logic [`RISCV_XLEN-1:0] imm;
  logic [`RISCV_XLEN-1:0] alu_a;
  logic [`RISCV_XLEN-1:0] alu_b;
  logic [shamt_w-1:0]     shamt;
  logic [`RISCV_XLEN-1:0] alu_result;
  logic [`RISCV_XLEN-1:0] wb_data;

  // Instruction fields
  assign inst_opcode = imem_rdata[6:0];
  assign inst_funct3 = imem_rdata[14:12];
  assign inst_funct7 = imem_rdata[31:25];
  assign rd_addr     = imem_rdata[11:7];
  assign rs1_addr    = imem_rdata[19:15];
  assign rs2_addr    = imem_rdata[24:20];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= `RISCV_RESET_PC;
    end else if (ctrl.pc_write_enable) begin
      pc <= next_pc;
    end
  end

  assign imem_addr = pc;
  assign pc_plus4  = pc + `RISCV_XLEN'd4;

  // Register file, x0 is never written and reads as zero
  assign rf_write = arst_n && ctrl.regfile_write_enable && (rd_addr != '0);

  always_ff @(posedge clk) begin
    if (rf_write) begin
      regs[rd_addr] <= wb_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  // Immediate formats
  assign imm_i = {{20{imem_rdata[31]}}, imem_rdata[31:20]};
  assign imm_s = {{20{imem_rdata[31]}}, imem_rdata[31:25], imem_rdata[11:7]};
  assign imm_b = {{19{imem_rdata[31]}}, imem_rdata[31], imem_rdata[7],
                  imem_rdata[30:25], imem_rdata[11:8], 1'b0};
  assign imm_u = {imem_rdata[31:12], 12'b0};
  assign imm_j = {{11{imem_rdata[31]}}, imem_rdata[31], imem_rdata[19:12],
                  imem_rdata[20], imem_rdata[30:21], 1'b0};

  always_comb begin
    case (opcode_e'(inst_opcode))
      opc_store:          imm = imm_s;
      opc_branch:         imm = imm_b;
      opc_lui, opc_auipc: imm = imm_u;
      opc_jal:            imm = imm_j;
      default:            imm = imm_i;
    endcase
  end

  // ALU
  assign alu_a = ctrl.alu_operand_a_select ? pc : rs1_data;
  assign alu_b = ctrl.alu_operand_b_select ? imm : rs2_data;
  assign shamt = alu_b[shamt_w-1:0];

  always_comb begin
    case (ctrl.alu_function)
      alu_add:  alu_result = alu_a + alu_b;
      alu_sub:  alu_result = alu_a - alu_b;
      alu_sll:  alu_result = alu_a << shamt;
      alu_slt:  alu_result = {{(`RISCV_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      alu_sltu: alu_result = {{(`RISCV_XLEN-1){1'b0}}, alu_a < alu_b};
      alu_xor:  alu_result = alu_a ^ alu_b;
      alu_srl:  alu_result = alu_a >> shamt;
      alu_sra:  alu_result = $signed(alu_a) >>> shamt;
      alu_or:   alu_result = alu_a | alu_b;
      alu_and:  alu_result = alu_a & alu_b;
      alu_seq:  alu_result = {{(`RISCV_XLEN-1){1'b0}}, alu_a == alu_b};
      alu_sne:  alu_result = {{(`RISCV_XLEN-1){1'b0}}, alu_a != alu_b};
      default:  alu_result = '0;
    endcase
  end

  assign alu_result_equal_zero = (alu_result == '0);

  always_comb begin
    case (ctrl.reg_writeback_select)
      wb_mem:      wb_data = dmem_rdata;
      wb_pc_plus4: wb_data = pc_plus4;
      wb_imm:      wb_data = imm;
      default:     wb_data = alu_result;
    endcase
  end

  always_comb begin
    case (ctrl.next_pc_select)
      pc_branch_target: next_pc = pc + imm;
      pc_jalr_target:   next_pc = {alu_result[`RISCV_XLEN-1:1], 1'b0};
      default:          next_pc = pc_plus4;
    endcase
  end

  // Data port, stores held off while in reset
  assign dmem_req.addr  = alu_result;
  assign dmem_req.wdata = rs2_data;
  assign dmem_req.read  = ctrl.data_mem_read_enable;
  assign dmem_req.write = ctrl.data_mem_write_enable && arst_n;

endmodule
